//--- run.sh
#!/usr/bin/env bash
# Build the vector store testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG" build.log

verilator --binary --timing --assert -Wno-fatal --top-module vstore_tb \
  -f tb.f --Mdir obj_dir -o vstore_sim > build.log 2>&1 \
  && ./obj_dir/vstore_sim > "$LOG" 2>&1 \
  || { cat build.log "$LOG" 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat "$LOG"
grep -q "Simulation failed" "$LOG" && exit 1
exit 0

//--- source/store_addr_gen.sv
/* Store address generator
   Splits the issue store into bursts on the address channel, queues them for the packer */
`timescale 1ns/1ns
`default_nettype none

module store_addr_gen import vstore_pkg::*; import wbus_pkg::*; #(
  parameter int unsigned NrLanes = 2
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Issue instruction from the queue
  input  store_req_t issue_insn_i,
  input  logic       issue_valid_i,
  // Address channel
  output burst_req_t aw_o,
  output logic       aw_valid_o,
  input  logic       aw_ready_i,
  // Accepted bursts toward the packer
  output burst_req_t burst_o,
  output logic       burst_valid_o,
  input  logic       burst_ready_i
);

  localparam int unsigned BeatBytes = LaneBytes * NrLanes;

  typedef enum logic [1:0] {
    IDLE,
    SEND,
    WAIT_NEXT
  } state_e;

  state_e      state_d, state_q;
  burst_req_t  aw_d, aw_q;
  logic        aw_valid_d, aw_valid_q;
  logic [7:0]  beats_left_d, beats_left_q;
  logic [31:0] next_addr_d, next_addr_q;

  // Two entry burst FIFO
  burst_req_t [1:0] fifo_q;
  logic             fifo_wr_q, fifo_rd_q;
  logic [1:0]       fifo_cnt_d, fifo_cnt_q;

  logic        aw_hs, fifo_pop, load;
  logic [7:0]  src_beats, chunk;
  logic [31:0] src_addr;

  assign aw_hs    = aw_valid_q && aw_ready_i;
  assign fifo_pop = burst_valid_o && burst_ready_i;

  // A burst enters the FIFO only once the bus took its address
  assign fifo_cnt_d    = fifo_cnt_q + 2'(aw_hs) - 2'(fifo_pop);
  assign burst_o       = fifo_q[fifo_rd_q];
  assign burst_valid_o = (fifo_cnt_q != '0);

  // First burst comes from the instruction, later ones from the counters
  assign src_beats = (state_q == IDLE) ?
                     beat_count(issue_insn_i.vl, issue_insn_i.vsew, BeatBytes) : beats_left_q;
  assign src_addr  = (state_q == IDLE) ? issue_insn_i.base_addr : next_addr_q;
  assign chunk     = (src_beats > 8'(MaxBurstBeats)) ? 8'(MaxBurstBeats) : src_beats;

  always_comb begin
    state_d      = state_q;
    aw_d         = aw_q;
    aw_valid_d   = aw_valid_q;
    beats_left_d = beats_left_q;
    next_addr_d  = next_addr_q;
    load         = 1'b0;

    if (aw_hs) begin
      aw_valid_d = 1'b0;
    end

    unique case (state_q)
      IDLE: begin
        if (issue_valid_i) begin
          load    = 1'b1;
          state_d = SEND;
        end
      end
      SEND: begin
        // Next address only when the current one is gone
        if (!aw_valid_q || aw_hs) begin
          if (beats_left_q == '0) begin
            state_d = WAIT_NEXT;
          end else if (fifo_cnt_d != 2'd2) begin
            load = 1'b1;
          end
        end
      end
      WAIT_NEXT: begin
        // Packer drained the last burst, issue pointer has moved
        if (fifo_cnt_q == '0) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase

    if (load) begin
      aw_d.addr    = src_addr;
      aw_d.len     = chunk - 8'd1;
      aw_valid_d   = 1'b1;
      beats_left_d = src_beats - chunk;
      next_addr_d  = src_addr + 32'(chunk) * BeatBytes;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      fifo_q[fifo_wr_q] <= aw_q;
    end
    aw_q         <= aw_d;
    beats_left_q <= beats_left_d;
    next_addr_q  <= next_addr_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      aw_valid_q <= 1'b0;
      fifo_wr_q  <= 1'b0;
      fifo_rd_q  <= 1'b0;
      fifo_cnt_q <= '0;
    end else begin
      state_q    <= state_d;
      aw_valid_q <= aw_valid_d;
      fifo_cnt_q <= fifo_cnt_d;
      if (aw_hs) begin
        fifo_wr_q <= !fifo_wr_q;
      end
      if (fifo_pop) begin
        fifo_rd_q <= !fifo_rd_q;
      end
    end
  end

  assign aw_o       = aw_q;
  assign aw_valid_o = aw_valid_q;

  // Stalled address request holds its payload
  a_aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o));

endmodule

`default_nettype wire

//--- source/store_beat_packer.sv
/* Store beat packer
   Packs lane words and mask into write beats, tracks burst and instruction progress */
`timescale 1ns/1ns
`default_nettype none

module store_beat_packer import vstore_pkg::*; import wbus_pkg::*; #(
  parameter int unsigned NrLanes = 2,
  parameter type w_beat_t = struct packed {
    lane_word_t [NrLanes-1:0] data;
    lane_strb_t [NrLanes-1:0] strb;
    logic                     last;
  }
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Issue instruction from the queue
  input  store_req_t               issue_insn_i,
  input  logic                     issue_valid_i,
  output logic                     insn_issued_o,
  // Bursts from the address generator
  input  burst_req_t               burst_i,
  input  logic                     burst_valid_i,
  output logic                     burst_ready_o,
  // Lanes
  input  lane_word_t [NrLanes-1:0] operand_i,
  input  logic       [NrLanes-1:0] operand_valid_i,
  output logic                     operand_ready_o,
  // Mask unit
  input  lane_strb_t [NrLanes-1:0] mask_i,
  input  logic       [NrLanes-1:0] mask_valid_i,
  output logic                     mask_ready_o,
  // Write data channel
  output w_beat_t                  w_o,
  output logic                     w_valid_o,
  input  logic                     w_ready_i
);

  localparam int unsigned BeatBytes = LaneBytes * NrLanes;
  // Fits 255 elements of 8 bytes
  localparam int unsigned ByteCntW  = 11;

  logic [7:0]           beat_cnt_q;
  logic [ByteCntW-1:0]  bytes_left_q, cur_bytes;
  logic                 started_q;
  logic [BeatBytes-1:0] mask_flat, strb;
  logic                 burst_last, insn_last, w_hs;

  // Bytes still to write, fresh instruction starts from vl scaled by element width
  assign cur_bytes = started_q ? bytes_left_q
                               : (ByteCntW'(issue_insn_i.vl) << issue_insn_i.vsew);

  // Mask bits line up with beat bytes
  assign mask_flat = mask_i;

  // Beat needs a burst, all lane words, and the mask when masked
  assign w_valid_o = issue_valid_i && burst_valid_i && (&operand_valid_i) &&
                     (issue_insn_i.vm || (&mask_valid_i));

  assign burst_last = (beat_cnt_q == burst_i.len);
  assign insn_last  = (cur_bytes <= ByteCntW'(BeatBytes));
  assign w_hs       = w_valid_o && w_ready_i;

  // Byte enabled below the tail and where the mask allows it
  always_comb begin
    for (int b = 0; b < BeatBytes; b++) begin
      strb[b] = (ByteCntW'(b) < cur_bytes) && (issue_insn_i.vm || mask_flat[b]);
    end
  end

  always_comb begin
    w_o.data = operand_i;
    w_o.strb = strb;
    w_o.last = burst_last;
  end

  // Operands and mask are only consumed by an accepted beat
  assign operand_ready_o = w_hs;
  assign mask_ready_o    = w_hs && !issue_insn_i.vm;
  assign burst_ready_o   = w_hs && burst_last;
  assign insn_issued_o   = w_hs && insn_last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt_q   <= '0;
      bytes_left_q <= '0;
      started_q    <= 1'b0;
    end else if (w_hs) begin
      beat_cnt_q   <= burst_last ? '0 : beat_cnt_q + 8'd1;
      // Next instruction reloads from its own vl
      started_q    <= !insn_last;
      bytes_left_q <= insn_last ? '0 : cur_bytes - ByteCntW'(BeatBytes);
    end
  end

  // Last beat of a store also closes its last burst
  a_insn_ends_burst: assert property (@(posedge clk_i) disable iff (!rst_ni)
    insn_issued_o |-> burst_ready_o);

endmodule

`default_nettype wire

//--- source/store_insn_queue.sv
/* Store instruction queue
   Holds in-flight stores, tracks issue and commit, counts bursts awaiting response */
`timescale 1ns/1ns
`default_nettype none

module store_insn_queue import vstore_pkg::*; import wbus_pkg::*; #(
  parameter int unsigned NrLanes = 2
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Sequencer
  input  store_req_t  req_i,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  output store_resp_t done_o,
  output logic        store_pending_o,
  // Issue side
  output store_req_t  issue_insn_o,
  output logic        issue_valid_o,
  input  logic        insn_issued_i,
  // Bus responses
  input  logic        b_valid_i
);

  localparam int unsigned PtrW      = $clog2(QueueDepth);
  localparam int unsigned BeatBytes = LaneBytes * NrLanes;

  // Entry payload and bursts still waiting for a response
  store_req_t [QueueDepth-1:0]      insn_q;
  logic       [QueueDepth-1:0][7:0] bursts_q;

  // Circular buffer pointers
  logic [PtrW-1:0] accept_pnt_q, issue_pnt_q, commit_pnt_q;
  // Entries waiting to be issued and to be committed
  logic [PtrW:0]   issue_cnt_q, commit_cnt_q;

  store_resp_t done_d, done_q;
  logic        accept;
  logic        commit_valid;
  logic        commit;

  // Full when every entry still waits for commit
  assign req_ready_o     = (commit_cnt_q != (PtrW+1)'(QueueDepth));
  assign commit_valid    = (commit_cnt_q != '0);
  assign store_pending_o = commit_valid;

  // Other units' requests are acknowledged and dropped
  assign accept = req_valid_i && req_ready_o && (req_i.vfu == VFU_STORE);

  assign issue_insn_o  = insn_q[issue_pnt_q];
  assign issue_valid_o = (issue_cnt_q != '0);

  // Last outstanding response of the commit entry
  assign commit = b_valid_i && commit_valid && (bursts_q[commit_pnt_q] == 8'd1);

  always_comb begin
    done_d = '0;
    if (commit) begin
      done_d.vinsn_done[insn_q[commit_pnt_q].id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    // Every response closes one burst of the commit entry
    if (b_valid_i && commit_valid) begin
      bursts_q[commit_pnt_q] <= bursts_q[commit_pnt_q] - 8'd1;
    end
    // New entry, burst count taken from vl, vsew and beat width
    if (accept) begin
      insn_q[accept_pnt_q]   <= req_i;
      bursts_q[accept_pnt_q] <= burst_count(beat_count(req_i.vl, req_i.vsew, BeatBytes));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      done_q       <= '0;
    end else begin
      // Pointers wrap on their own, depth is a power of two
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (insn_issued_i) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      if (commit) begin
        commit_pnt_q <= commit_pnt_q + 1'b1;
      end
      issue_cnt_q  <= issue_cnt_q + (PtrW+1)'(accept) - (PtrW+1)'(insn_issued_i);
      commit_cnt_q <= commit_cnt_q + (PtrW+1)'(accept) - (PtrW+1)'(commit);
      // One cycle done pulse
      done_q       <= done_d;
    end
  end

  assign done_o = done_q;

  // Bus never answers a burst that no queued store sent
  a_resp_has_owner: assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_valid_i |-> commit_valid);

  a_commit_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_cnt_q <= (PtrW+1)'(QueueDepth));

endmodule

`default_nettype wire

//--- source/vector_store_unit.sv
/* Vector store unit top
   Queue, address generator and beat packer between sequencer, lanes and write bus */
`timescale 1ns/1ns
`default_nettype none

module vector_store_unit import vstore_pkg::*; import wbus_pkg::*; #(
  parameter int unsigned NrLanes = 2,
  parameter type w_beat_t = struct packed {
    lane_word_t [NrLanes-1:0] data;
    lane_strb_t [NrLanes-1:0] strb;
    logic                     last;
  },
  parameter type b_resp_t = struct packed {
    resp_t resp;
  }
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Sequencer
  input  store_req_t               req_i,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  output store_resp_t              done_o,
  output logic                     store_pending_o,
  // Lanes
  input  lane_word_t [NrLanes-1:0] operand_i,
  input  logic       [NrLanes-1:0] operand_valid_i,
  output logic                     operand_ready_o,
  // Mask unit
  input  lane_strb_t [NrLanes-1:0] mask_i,
  input  logic       [NrLanes-1:0] mask_valid_i,
  output logic                     mask_ready_o,
  // Write bus
  output burst_req_t               aw_o,
  output logic                     aw_valid_o,
  input  logic                     aw_ready_i,
  output w_beat_t                  w_o,
  output logic                     w_valid_o,
  input  logic                     w_ready_i,
  input  b_resp_t                  b_i,
  input  logic                     b_valid_i,
  output logic                     b_ready_o
);

  store_req_t issue_insn;
  logic       issue_valid;
  logic       insn_issued;
  burst_req_t burst;
  logic       burst_valid, burst_ready;

  // Responses are always taken, error codes in b_i are not acted on
  assign b_ready_o = 1'b1;

  store_insn_queue #(
    .NrLanes(NrLanes)
  ) i_queue (
    .clk_i,
    .rst_ni,
    .req_i,
    .req_valid_i,
    .req_ready_o,
    .done_o,
    .store_pending_o,
    .issue_insn_o (issue_insn),
    .issue_valid_o(issue_valid),
    .insn_issued_i(insn_issued),
    .b_valid_i
  );

  store_addr_gen #(
    .NrLanes(NrLanes)
  ) i_addr_gen (
    .clk_i,
    .rst_ni,
    .issue_insn_i (issue_insn),
    .issue_valid_i(issue_valid),
    .aw_o,
    .aw_valid_o,
    .aw_ready_i,
    .burst_o      (burst),
    .burst_valid_o(burst_valid),
    .burst_ready_i(burst_ready)
  );

  store_beat_packer #(
    .NrLanes (NrLanes),
    .w_beat_t(w_beat_t)
  ) i_packer (
    .clk_i,
    .rst_ni,
    .issue_insn_i (issue_insn),
    .issue_valid_i(issue_valid),
    .insn_issued_o(insn_issued),
    .burst_i      (burst),
    .burst_valid_i(burst_valid),
    .burst_ready_o(burst_ready),
    .operand_i,
    .operand_valid_i,
    .operand_ready_o,
    .mask_i,
    .mask_valid_i,
    .mask_ready_o,
    .w_o,
    .w_valid_o,
    .w_ready_i
  );

endmodule

`default_nettype wire

//--- source/vstore_pkg.sv
/* Vector store instruction side
   Sequencer request and done response types, id and queue sizing */
`default_nettype none

package vstore_pkg;

  // Stores that may be in flight at once
  localparam int unsigned QueueDepth = 4;
  // Instruction ids handed out by the sequencer
  localparam int unsigned NrVInsn = 8;

  // Element width, value is the byte shift of one element
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } ew_e;

  // Target functional unit of a sequencer request
  typedef enum logic [1:0] {
    VFU_ALU,
    VFU_LOAD,
    VFU_STORE
  } vfu_e;

  typedef struct packed {
    logic [$clog2(NrVInsn)-1:0] id;
    vfu_e                       vfu;
    ew_e                        vsew;
    logic                       vm;         // 1 when unmasked
    logic [7:0]                 vl;         // Element count
    logic [31:0]                base_addr;  // Beat aligned
  } store_req_t;

  // One done bit per instruction id
  typedef struct packed {
    logic [NrVInsn-1:0] vinsn_done;
  } store_resp_t;

  // Write beats needed by one store, rounded up
  function automatic logic [7:0] beat_count(logic [7:0] vl, ew_e vsew, int unsigned beat_bytes);
    int unsigned bytes;
    bytes = 32'(vl) << vsew;
    return 8'((bytes + beat_bytes - 1) / beat_bytes);
  endfunction

endpackage

`default_nettype wire

//--- source/wbus_pkg.sv
/* Write bus types
   Burst requests, lane word and strobe slices, response code, burst limit */
`default_nettype none

package wbus_pkg;

  // Longest burst on the address channel, in beats
  localparam int unsigned MaxBurstBeats = 4;
  // Each lane delivers one 64-bit word per beat
  localparam int unsigned LaneBytes = 8;

  // Slices of a write beat, one per lane
  typedef logic [8*LaneBytes-1:0] lane_word_t;
  typedef logic [LaneBytes-1:0]   lane_strb_t;

  // Write response code
  typedef logic [1:0] resp_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  len;   // Beats minus one
  } burst_req_t;

  // Bursts needed for a given beat count, rounded up
  function automatic logic [7:0] burst_count(logic [7:0] beats);
    return 8'((32'(beats) + MaxBurstBeats - 1) / MaxBurstBeats);
  endfunction

endpackage

`default_nettype wire

//--- tb.f
+incdir+verif
source/vstore_pkg.sv
source/wbus_pkg.sv
source/store_insn_queue.sv
source/store_addr_gen.sv
source/store_beat_packer.sv
source/vector_store_unit.sv
verif/vstore_tb.sv

//--- verif/vstore_tb_tasks.svh
/* Directed tests for the vector store unit
   Each test sends stores, waits for done pulses and checks the bus traffic */

  // Holds valid until the queue takes the request
  task automatic wait_accept();
    @(posedge clk_i);
    while (!req_ready_o) begin
      @(posedge clk_i);
    end
    req_valid_i <= 1'b0;
  endtask

  task automatic send_req(input store_req_t r);
    @(posedge clk_i);
    req_i       <= r;
    req_valid_i <= 1'b1;
    wait_accept();
  endtask

  // Waits for n done pulses, then a few more cycles to catch extra ones
  task automatic wait_dones(input int unsigned n);
    while (done_log.size() < n) begin
      @(posedge clk_i);
    end
    repeat (6) @(posedge clk_i);
    if (done_log.size() != n) begin
      fault($sformatf("%0d done pulses seen, %0d expected", done_log.size(), n));
    end
  endtask

  // Done ids expected in order, starting at first_id and wrapping
  task automatic check_done(input int unsigned first_id, input int unsigned n);
    int unsigned id;
    wait_dones(n);
    for (int unsigned i = 0; i < n && i < done_log.size(); i++) begin
      id = (first_id + i) % NrVInsn;
      if (done_log[i] != id) report_mismatch("done_o id", done_log[i], id);
    end
    done_log.delete();
  endtask

  // Expected bursts and beats rebuilt from vl, element width and base address
  task automatic check_store(input logic [31:0] base, input ew_e vsew, input logic [7:0] vl,
                             input logic vm);
    int unsigned          bytes;
    int unsigned          beats;
    int unsigned          chunk;
    int unsigned          beat;
    logic [31:0]          addr;
    logic [BeatBytes-1:0] mask;
    logic [BeatBytes-1:0] exp_strb;
    burst_req_t           aw;
    w_beat_t              w;
    bytes = 32'(vl) << vsew;
    beats = (bytes + BeatBytes - 1) / BeatBytes;
    beat  = 0;
    addr  = base;
    while (beat < beats) begin
      // Full bursts first, the rest in the last one
      chunk = (beats - beat > MaxBurstBeats) ? MaxBurstBeats : beats - beat;
      if (aw_log.size() == 0) begin
        fault($sformatf("no address burst for beat %0d of store at %h", beat, base));
        return;
      end
      aw = aw_log.pop_front();
      if (aw.addr !== addr) report_mismatch("aw_o.addr", aw.addr, addr);
      if (aw.len !== 8'(chunk - 1)) report_mismatch("aw_o.len", aw.len, chunk - 1);
      for (int unsigned i = 0; i < chunk; i++) begin
        if (w_log.size() == 0) begin
          fault($sformatf("write beat %0d of store at %h never arrived", beat, base));
          return;
        end
        w    = w_log.pop_front();
        mask = vm ? '1 : mask_pattern(exp_mk);
        // Bytes past the end of the store stay disabled
        for (int unsigned b = 0; b < BeatBytes; b++) begin
          exp_strb[b] = (beat * BeatBytes + b < bytes) && mask[b];
        end
        if (w.data !== beat_operands(exp_op)) begin
          report_mismatch("w_o.data", w.data, beat_operands(exp_op));
        end
        if (w.strb !== exp_strb) report_mismatch("w_o.strb", w.strb, exp_strb);
        if (w.last !== (i == chunk - 1)) report_mismatch("w_o.last", w.last, i == chunk - 1);
        exp_op++;
        if (!vm) begin
          exp_mk++;
        end
        beat++;
      end
      addr = addr + chunk * BeatBytes;
    end
  endtask

  task automatic end_test(input string name, input int unsigned errs_before);
    if (aw_log.size() != 0 || w_log.size() != 0) begin
      fault("unexpected bus traffic after the checked stores");
    end
    // Resync so one broken test does not spill into the next
    aw_log.delete();
    w_log.delete();
    done_log.delete();
    exp_op = op_idx;
    exp_mk = mk_idx;
    tests++;
    if (errors == errs_before) begin
      $display("[%0t ns] %s: ok", $time, name);
    end else begin
      $display("[%0t ns] %s: %0d errors", $time, name, errors - errs_before);
    end
  endtask

  // EW64, vl 6 is 48 bytes, three beats in one burst
  task automatic single_unmasked_store();
    int unsigned errs;
    errs = errors;
    send_req(store_req(3'd3, VFU_STORE, EW64, 1'b1, 8'd6, 32'h0000_1000));
    check_done(3, 1);
    check_store(32'h0000_1000, EW64, 8'd6, 1'b1);
    end_test("single unmasked store", errs);
  endtask

  // EW8, vl 100 is seven beats, bursts of 4 and 3, tail of 4 bytes
  task automatic split_and_tail();
    int unsigned errs;
    errs = errors;
    send_req(store_req(3'd4, VFU_STORE, EW8, 1'b1, 8'd100, 32'h0000_2000));
    check_done(4, 1);
    check_store(32'h0000_2000, EW8, 8'd100, 1'b1);
    end_test("burst split and tail strobes", errs);
  endtask

  task automatic masked_store();
    int unsigned errs;
    int unsigned mk_before;
    errs      = errors;
    mk_before = mk_idx;
    send_req(store_req(3'd5, VFU_STORE, EW16, 1'b0, 8'd20, 32'h0000_3000));
    check_done(5, 1);
    // 40 bytes, so three mask words taken
    if (mk_idx - mk_before != 3) report_mismatch("mask_ready_o pulses", mk_idx - mk_before, 3);
    check_store(32'h0000_3000, EW16, 8'd20, 1'b0);
    end_test("masked store", errs);
  endtask

  // Responses held back, ids 6 to 2 to cover id wrap
  task automatic queue_full_overlap();
    int unsigned errs;
    int unsigned waited;
    errs = errors;
    b_hold <= 1'b1;
    for (int unsigned i = 0; i < 4; i++) begin
      send_req(store_req(3'(6 + i), VFU_STORE, EW64, 1'b1, 8'd2, 32'h4000 + i * 32'h40));
    end
    // Fifth store waits for a free entry
    @(posedge clk_i);
    req_i       <= store_req(3'd2, VFU_STORE, EW64, 1'b1, 8'd2, 32'h4100);
    req_valid_i <= 1'b1;
    repeat (8) begin
      @(posedge clk_i);
      if (req_ready_o !== 1'b0) report_mismatch("req_ready_o", req_ready_o, 1'b0);
      if (store_pending_o !== 1'b1) report_mismatch("store_pending_o", store_pending_o, 1'b1);
    end
    // Later stores issue their beats while earlier responses are outstanding
    waited = 0;
    while (w_log.size() < 4 && waited < 100) begin
      @(posedge clk_i);
      waited++;
    end
    if (w_log.size() != 4) fault("queued stores did not issue while responses were held back");
    if (done_log.size() != 0) fault("a store finished while its response was held back");
    b_hold <= 1'b0;
    wait_accept();
    check_done(6, 5);
    for (int unsigned i = 0; i < 5; i++) begin
      check_store(32'h4000 + i * 32'h40, EW64, 8'd2, 1'b1);
    end
    end_test("queue full and overlap", errs);
  endtask

  task automatic alu_drop_backpressure();
    int unsigned errs;
    errs = errors;
    send_req(store_req(3'd1, VFU_ALU, EW64, 1'b1, 8'd8, 32'h0000_5000));
    repeat (20) @(posedge clk_i);
    if (aw_log.size() != 0 || w_log.size() != 0) fault("ALU request caused bus traffic");
    if (done_log.size() != 0) fault("ALU request produced a done pulse");
    if (store_pending_o !== 1'b0) report_mismatch("store_pending_o", store_pending_o, 1'b0);
    // Random ready on address and write data channels
    rand_ready <= 1'b1;
    send_req(store_req(3'd2, VFU_STORE, EW32, 1'b1, 8'd40, 32'h0000_6000));
    send_req(store_req(3'd3, VFU_STORE, EW16, 1'b1, 8'd72, 32'h0000_7000));
    check_done(2, 2);
    rand_ready <= 1'b0;
    check_store(32'h0000_6000, EW32, 8'd40, 1'b1);
    check_store(32'h0000_7000, EW16, 8'd72, 1'b1);
    end_test("non-store request and back-pressure", errs);
  endtask

//--- verif/vstore_tb.sv
/* Vector store unit testbench
   Lane and mask sources, write bus responder, timeout and final report */
`timescale 1ns/1ns
`default_nettype none

module vstore_tb import vstore_pkg::*; import wbus_pkg::*; ();

  localparam int unsigned NrLanes   = 2;
  localparam int unsigned BeatBytes = LaneBytes * NrLanes;
  // Five tests need a few hundred cycles, random back-pressure roughly doubles that
  localparam int unsigned TimeoutCycles = 4000;

  // Same layout as the beat type inside the DUT
  typedef struct packed {
    lane_word_t [NrLanes-1:0] data;
    lane_strb_t [NrLanes-1:0] strb;
    logic                     last;
  } w_beat_t;

  logic                     clk_i;
  logic                     rst_ni;
  store_req_t               req_i;
  logic                     req_valid_i;
  logic                     req_ready_o;
  store_resp_t              done_o;
  logic                     store_pending_o;
  lane_word_t [NrLanes-1:0] operand_i;
  logic       [NrLanes-1:0] operand_valid_i;
  logic                     operand_ready_o;
  lane_strb_t [NrLanes-1:0] mask_i;
  logic       [NrLanes-1:0] mask_valid_i;
  logic                     mask_ready_o;
  burst_req_t               aw_o;
  logic                     aw_valid_o, aw_ready_i;
  w_beat_t                  w_o;
  logic                     w_valid_o, w_ready_i;
  logic [1:0]               b_i;
  logic                     b_valid_i, b_ready_o;

  // Source cursors, advanced by the DUT's ready pulses
  int unsigned op_idx, mk_idx;
  // Checker cursors, advanced per checked beat
  int unsigned exp_op, exp_mk;

  // Traffic seen on the bus and done ids in arrival order
  burst_req_t  aw_log[$];
  w_beat_t     w_log[$];
  int unsigned done_log[$];

  // Finished bursts still owed a response
  int unsigned owed_b;
  logic        b_hold, rand_ready;
  logic [31:0] lfsr_q;
  int unsigned cycles, errors, tests;

  vector_store_unit #(
    .NrLanes(NrLanes)
  ) DUT (
    .clk_i,
    .rst_ni,
    .req_i,
    .req_valid_i,
    .req_ready_o,
    .done_o,
    .store_pending_o,
    .operand_i,
    .operand_valid_i,
    .operand_ready_o,
    .mask_i,
    .mask_valid_i,
    .mask_ready_o,
    .aw_o,
    .aw_valid_o,
    .aw_ready_i,
    .w_o,
    .w_valid_o,
    .w_ready_i,
    .b_i,
    .b_valid_i,
    .b_ready_o
  );

  always #4 clk_i = ~clk_i;

  // Lane word as a function of beat index and lane, so every beat differs
  function automatic lane_word_t lane_word(int unsigned k, int unsigned l);
    return {8'(8'hc0 + l), 24'(k), 32'(k * 32'h9e37_79b9 + l)};
  endfunction

  function automatic logic [NrLanes*64-1:0] beat_operands(int unsigned k);
    logic [NrLanes*64-1:0] v;
    for (int unsigned l = 0; l < NrLanes; l++) begin
      v[l*64 +: 64] = lane_word(k, l);
    end
    return v;
  endfunction

  // Byte mask per masked beat
  function automatic logic [BeatBytes-1:0] mask_pattern(int unsigned k);
    return BeatBytes'((k * 32'h0000_6d2b) ^ 32'h0000_c3a5);
  endfunction

  // Galois LFSR, one step per bit taken from bit 0
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic store_req_t store_req(input logic [2:0]  id,
                                           input vfu_e        vfu,
                                           input ew_e         vsew,
                                           input logic        vm,
                                           input logic [7:0]  vl,
                                           input logic [31:0] base);
    store_req_t r;
    r.id        = id;
    r.vfu       = vfu;
    r.vsew      = vsew;
    r.vm        = vm;
    r.vl        = vl;
    r.base_addr = base;
    return r;
  endfunction

  task automatic report_mismatch(input string sig, input logic [127:0] got,
                                 input logic [127:0] exp);
    $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, sig, got, exp);
    errors++;
  endtask

  task automatic fault(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    errors++;
  endtask

  `include "vstore_tb_tasks.svh"

  // Lanes and mask unit present the next word once the current one is taken
  always @(posedge clk_i) begin
    if (operand_ready_o) begin
      op_idx    <= op_idx + 1;
      operand_i <= beat_operands(op_idx + 1);
    end
    if (mask_ready_o) begin
      mk_idx <= mk_idx + 1;
      mask_i <= mask_pattern(mk_idx + 1);
    end
  end

  // Bus responder, one response per burst after its last beat
  always @(posedge clk_i) begin
    if (aw_valid_o && aw_ready_i) begin
      aw_log.push_back(aw_o);
    end
    if (w_valid_o && w_ready_i) begin
      w_log.push_back(w_o);
      if (w_o.last) begin
        owed_b = owed_b + 1;
      end
    end
    // A response is only delivered when the DUT takes it
    if (b_valid_i && b_ready_o !== 1'b1) begin
      report_mismatch("b_ready_o", b_ready_o, 1'b1);
    end
    if (!b_hold && owed_b != 0) begin
      b_valid_i <= 1'b1;
      owed_b = owed_b - 1;
    end else begin
      b_valid_i <= 1'b0;
    end
    // Ready patterns from the LFSR when back-pressure is on
    if (rand_ready) begin
      aw_ready_i <= lfsr_q[0];
      lfsr_q = lfsr_step(lfsr_q);
      w_ready_i <= lfsr_q[0];
      lfsr_q = lfsr_step(lfsr_q);
    end else begin
      aw_ready_i <= 1'b1;
      w_ready_i  <= 1'b1;
    end
  end

  // Done ids in arrival order
  always @(posedge clk_i) begin
    for (int unsigned i = 0; i < NrVInsn; i++) begin
      if (done_o.vinsn_done[i]) begin
        done_log.push_back(i);
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == TimeoutCycles) begin
      $display("Timeout after %0d cycles, a test never finished", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    req_i           = '0;
    req_valid_i     = 1'b0;
    operand_i       = beat_operands(0);
    operand_valid_i = '1;
    mask_i          = mask_pattern(0);
    mask_valid_i    = '1;
    aw_ready_i      = 1'b1;
    w_ready_i       = 1'b1;
    b_i             = '0;
    b_valid_i       = 1'b0;
    op_idx          = 0;
    mk_idx          = 0;
    exp_op          = 0;
    exp_mk          = 0;
    owed_b          = 0;
    b_hold          = 1'b0;
    rand_ready      = 1'b0;
    lfsr_q          = 32'hf869_9328;
    cycles          = 0;
    errors          = 0;
    tests           = 0;

    repeat (5) @(posedge clk_i);
    // Outputs quiet while in reset
    if (aw_valid_o !== 1'b0) report_mismatch("aw_valid_o", aw_valid_o, 1'b0);
    if (w_valid_o !== 1'b0) report_mismatch("w_valid_o", w_valid_o, 1'b0);
    if (operand_ready_o !== 1'b0) report_mismatch("operand_ready_o", operand_ready_o, 1'b0);
    if (mask_ready_o !== 1'b0) report_mismatch("mask_ready_o", mask_ready_o, 1'b0);
    if (done_o !== '0) report_mismatch("done_o", done_o, '0);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    single_unmasked_store();
    split_and_tail();
    masked_store();
    queue_full_overlap();
    alu_drop_backpressure();

    $display("Tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
